// File: include/lsu_params.svh
//**************************************************************************
// LSU widths and memory map
//**************************************************************************
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath widths
`define LSU_ADDR_W      32
`define LSU_DATA_W      64
`define LSU_OFFSET_W    12

// DCCM window, 64 KB
`define LSU_DCCM_BASE   32'hF004_0000
`define LSU_DCCM_BITS   16

// PIC register window
`define LSU_PIC_BASE    32'hF00C_0000
`define LSU_PIC_BITS    15

`endif

// File: hdl/lsu_pkg.sv
//**************************************************************************
// LSU shared types
//**************************************************************************
`include "lsu_params.svh"

package lsu_pkg;

   // Widths with a meaning of their own
   typedef logic [`LSU_ADDR_W-1:0]          addr_t;
   typedef logic [`LSU_DATA_W-1:0]          data_t;
   typedef logic signed [`LSU_OFFSET_W-1:0] offset_t;

   // Access size, also the low two bits of the DMA size code
   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,
      SZ_HALF  = 2'd1,
      SZ_WORD  = 2'd2,
      SZ_DWORD = 2'd3
   } lsu_size_e;

   // Control packet that follows an access down the pipe
   typedef struct packed {
      logic      valid;
      logic      dma;
      logic      load;
      logic      store;
      logic      unsign;
      lsu_size_e size;
   } lsu_pkt_t;

endpackage

// File: hdl/lsu_stage_if.sv
//**************************************************************************
// LSU stage bundle
//**************************************************************************
interface lsu_stage_if;

   // Packet and address of the access in this stage
   lsu_pkg::lsu_pkt_t pkt;
   lsu_pkg::addr_t    addr;
   lsu_pkg::addr_t    end_addr;

   // Region of the start address, exactly one is set
   logic              in_dccm;
   logic              in_pic;
   logic              external;

   // Faults found by the memory-map check
   logic              access_fault;
   logic              misaligned_fault;

   // Address generator side
   modport gen (
      output pkt, addr, end_addr,
      input  in_dccm, in_pic, external, access_fault, misaligned_fault
   );

   // Memory-map checker side
   modport chk (
      input  pkt, addr, end_addr,
      output in_dccm, in_pic, external, access_fault, misaligned_fault
   );

   // Pipe register output
   modport src (
      output pkt, addr, end_addr,
      output in_dccm, in_pic, external, access_fault, misaligned_fault
   );

   // Consumers of a whole stage
   modport snk (
      input  pkt, addr, end_addr,
      input  in_dccm, in_pic, external, access_fault, misaligned_fault
   );

endinterface

// File: hdl/lsu_dc1_stage.sv
//**************************************************************************
// LSU request select and DC1 address generation
//**************************************************************************
`include "lsu_params.svh"

module lsu_dc1_stage (
   input  logic               clk,
   input  logic               rst_n,
   // Core request in D
   input  logic               core_valid,
   input  logic               core_load,
   input  logic               core_store,
   input  logic               core_unsign,
   input  lsu_pkg::lsu_size_e core_size,
   input  lsu_pkg::addr_t     core_rs1,
   input  lsu_pkg::offset_t   core_offset,
   input  logic               flush_dc2_up,
   // DMA request in D
   input  logic               dma_dccm_req,
   input  lsu_pkg::addr_t     dma_mem_addr,
   input  logic [2:0]         dma_mem_sz,
   input  logic               dma_mem_write,
   lsu_stage_if.gen           dc1
);

   lsu_pkg::lsu_pkt_t core_pkt_d;
   lsu_pkg::lsu_pkt_t dma_pkt_d;
   lsu_pkg::lsu_pkt_t pkt_dc1;
   lsu_pkg::addr_t    rs1_dc1;
   lsu_pkg::offset_t  offset_dc1;
   lsu_pkg::addr_t    offset_ext_dc1;
   lsu_pkg::addr_t    start_addr_dc1;
   logic [2:0]        size_off_dc1;

   //************************************************************************
   // D stage request select
   //************************************************************************
   always_comb begin
      core_pkt_d.valid  = core_valid & ~flush_dc2_up;
      core_pkt_d.dma    = 1'b0;
      core_pkt_d.load   = core_load;
      core_pkt_d.store  = core_store;
      core_pkt_d.unsign = core_unsign;
      core_pkt_d.size   = core_size;

      // DMA always enters, even under a flush
      dma_pkt_d.valid   = dma_dccm_req;
      dma_pkt_d.dma     = 1'b1;
      dma_pkt_d.load    = ~dma_mem_write;
      dma_pkt_d.store   = dma_mem_write;
      dma_pkt_d.unsign  = 1'b0;
      dma_pkt_d.size    = lsu_pkg::lsu_size_e'(dma_mem_sz[1:0]);
   end

   // D to DC1, DMA wins and carries no offset
   always_ff @(posedge clk) begin
      pkt_dc1    <= dma_dccm_req ? dma_pkt_d : core_pkt_d;
      rs1_dc1    <= dma_dccm_req ? dma_mem_addr : core_rs1;
      offset_dc1 <= dma_dccm_req ? '0 : core_offset;
      if (!rst_n) begin
         pkt_dc1.valid <= 1'b0;
      end
   end

   //************************************************************************
   // DC1 start and end address
   //************************************************************************
   assign offset_ext_dc1 = {{(`LSU_ADDR_W-`LSU_OFFSET_W){offset_dc1[`LSU_OFFSET_W-1]}},
                            offset_dc1};
   assign start_addr_dc1 = rs1_dc1 + offset_ext_dc1;

   // Bytes in the access minus one
   always_comb begin
      case (pkt_dc1.size)
         lsu_pkg::SZ_BYTE: size_off_dc1 = 3'd0;
         lsu_pkg::SZ_HALF: size_off_dc1 = 3'd1;
         lsu_pkg::SZ_WORD: size_off_dc1 = 3'd3;
         default:          size_off_dc1 = 3'd7;
      endcase
   end

   assign dc1.pkt      = pkt_dc1;
   assign dc1.addr     = start_addr_dc1;
   assign dc1.end_addr = start_addr_dc1 + {{(`LSU_ADDR_W-3){1'b0}}, size_off_dc1};

endmodule

// File: hdl/lsu_addrcheck.sv
//**************************************************************************
// LSU memory-map check
//**************************************************************************
`include "lsu_params.svh"

module lsu_addrcheck (
   lsu_stage_if.chk dc1
);

   logic start_dccm;
   logic start_pic;
   logic end_dccm;
   logic end_pic;
   logic unaligned;
   logic region_cross;
   logic pic_bad_size;
   logic misaligned;

   // Address falls in the window when all bits above its size match the base
   function automatic logic in_region(lsu_pkg::addr_t a, lsu_pkg::addr_t base, int bits);
      return (a >> bits) == (base >> bits);
   endfunction

   assign start_dccm = in_region(dc1.addr, `LSU_DCCM_BASE, `LSU_DCCM_BITS);
   assign start_pic  = in_region(dc1.addr, `LSU_PIC_BASE, `LSU_PIC_BITS);
   assign end_dccm   = in_region(dc1.end_addr, `LSU_DCCM_BASE, `LSU_DCCM_BITS);
   assign end_pic    = in_region(dc1.end_addr, `LSU_PIC_BASE, `LSU_PIC_BITS);

   // Region flags follow the start address
   assign dc1.in_dccm  = start_dccm;
   assign dc1.in_pic   = start_pic & ~start_dccm;
   assign dc1.external = ~start_dccm & ~start_pic;

   // Natural alignment per size
   always_comb begin
      case (dc1.pkt.size)
         lsu_pkg::SZ_BYTE: unaligned = 1'b0;
         lsu_pkg::SZ_HALF: unaligned = dc1.addr[0];
         lsu_pkg::SZ_WORD: unaligned = |dc1.addr[1:0];
         default:          unaligned = |dc1.addr[2:0];
      endcase
   end

   // DCCM takes unaligned accesses, other regions fault
   assign misaligned = dc1.pkt.valid & unaligned & ~start_dccm;

   // With only three regions any change of region touches DCCM or PIC
   assign region_cross = (start_dccm != end_dccm) | (start_pic != end_pic);

   // PIC registers are word access only
   assign pic_bad_size = start_pic & (dc1.pkt.size != lsu_pkg::SZ_WORD);

   assign dc1.misaligned_fault = misaligned;
   assign dc1.access_fault     = dc1.pkt.valid & ~misaligned & (region_cross | pic_bad_size);

endmodule

// File: hdl/lsu_stage_pipe.sv
//**************************************************************************
// LSU DC1 to DC5 pipe registers
//**************************************************************************
module lsu_stage_pipe (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              flush_dc2_up,
   input  logic              flush_dc3,
   input  logic              flush_dc4,
   lsu_stage_if.snk          dc1,
   lsu_stage_if.src          dc3,
   output logic              lsu_exc_dc2,
   output lsu_pkg::lsu_pkt_t pkt_dc5,
   output lsu_pkg::addr_t    lsu_addr_dc5
);

   // Region and fault flags, moved as one word
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
      logic access_fault;
      logic misaligned_fault;
   } flags_t;

   flags_t            flags_dc1;
   flags_t            flags_dc2;
   flags_t            flags_dc3;
   lsu_pkg::lsu_pkt_t pkt_dc2;
   lsu_pkg::lsu_pkt_t pkt_dc3;
   lsu_pkg::lsu_pkt_t pkt_dc4;
   lsu_pkg::addr_t    addr_dc2;
   lsu_pkg::addr_t    addr_dc3;
   lsu_pkg::addr_t    addr_dc4;
   lsu_pkg::addr_t    end_addr_dc2;
   lsu_pkg::addr_t    end_addr_dc3;

   // A flush drops core packets, DMA keeps going
   function automatic lsu_pkg::lsu_pkt_t kill_core(lsu_pkg::lsu_pkt_t pkt, logic flush);
      lsu_pkg::lsu_pkt_t res;
      res       = pkt;
      res.valid = pkt.valid & ~(flush & ~pkt.dma);
      return res;
   endfunction

   assign flags_dc1 = '{in_dccm:          dc1.in_dccm,
                        in_pic:           dc1.in_pic,
                        external:         dc1.external,
                        access_fault:     dc1.access_fault,
                        misaligned_fault: dc1.misaligned_fault};

   //************************************************************************
   // Packet valid chain
   //************************************************************************
   always_ff @(posedge clk) begin
      pkt_dc2 <= kill_core(dc1.pkt, flush_dc2_up);
      pkt_dc3 <= kill_core(pkt_dc2, flush_dc2_up);
      pkt_dc4 <= kill_core(pkt_dc3, flush_dc3);
      pkt_dc5 <= kill_core(pkt_dc4, flush_dc4);
      if (!rst_n) begin
         pkt_dc2.valid <= 1'b0;
         pkt_dc3.valid <= 1'b0;
         pkt_dc4.valid <= 1'b0;
         pkt_dc5.valid <= 1'b0;
      end
   end

   // Addresses and flags
   always_ff @(posedge clk) begin
      addr_dc2     <= dc1.addr;
      addr_dc3     <= addr_dc2;
      addr_dc4     <= addr_dc3;
      lsu_addr_dc5 <= addr_dc4;
      end_addr_dc2 <= dc1.end_addr;
      end_addr_dc3 <= end_addr_dc2;
      flags_dc2    <= flags_dc1;
      flags_dc3    <= flags_dc2;
   end

   assign lsu_exc_dc2 = flags_dc2.access_fault | flags_dc2.misaligned_fault;

   // DC3 view
   assign dc3.pkt              = pkt_dc3;
   assign dc3.addr             = addr_dc3;
   assign dc3.end_addr         = end_addr_dc3;
   assign dc3.in_dccm          = flags_dc3.in_dccm;
   assign dc3.in_pic           = flags_dc3.in_pic;
   assign dc3.external         = flags_dc3.external;
   assign dc3.access_fault     = flags_dc3.access_fault;
   assign dc3.misaligned_fault = flags_dc3.misaligned_fault;

endmodule

// File: hdl/lsu_ld_align.sv
//**************************************************************************
// LSU DC3 load result
//**************************************************************************
`include "lsu_params.svh"

module lsu_ld_align (
   lsu_stage_if.snk       dc3,
   input  lsu_pkg::data_t lsu_ld_data_dc3,
   input  lsu_pkg::data_t bus_read_data_dc3,
   output lsu_pkg::data_t lsu_result_dc3
);

   lsu_pkg::data_t ld_data;
   logic           sext;

   // External loads return on the bus, the rest from DCCM
   assign ld_data = dc3.external ? bus_read_data_dc3 : lsu_ld_data_dc3;
   assign sext    = ~dc3.pkt.unsign;

   always_comb begin
      case (dc3.pkt.size)
         lsu_pkg::SZ_BYTE: begin
            lsu_result_dc3 = {{(`LSU_DATA_W-8){sext & ld_data[7]}}, ld_data[7:0]};
         end
         lsu_pkg::SZ_HALF: begin
            lsu_result_dc3 = {{(`LSU_DATA_W-16){sext & ld_data[15]}}, ld_data[15:0]};
         end
         lsu_pkg::SZ_WORD: begin
            lsu_result_dc3 = {{(`LSU_DATA_W-32){sext & ld_data[31]}}, ld_data[31:0]};
         end
         // Dword fills the whole result
         default: begin
            lsu_result_dc3 = ld_data;
         end
      endcase
   end

endmodule

// File: hdl/lsu_trap_commit.sv
//**************************************************************************
// LSU exception report and commit
//**************************************************************************
module lsu_trap_commit (
   lsu_stage_if.snk          dc3,
   input  logic              ld_bus_error_dc3,
   input  logic              flush_dc3,
   input  lsu_pkg::lsu_pkt_t pkt_dc5,
   input  logic              flush_dc5,
   output logic              exc_valid_dc3,
   output logic              exc_type_dc3,
   output logic              exc_store_dc3,
   output lsu_pkg::addr_t    exc_addr_dc3,
   output logic              lsu_commit_dc5
);

   logic any_fault_dc3;

   //************************************************************************
   // DC3 exception report
   //************************************************************************
   assign any_fault_dc3 = dc3.access_fault | dc3.misaligned_fault | ld_bus_error_dc3;

   // DMA errors go back on the DMA side, never as a trap
   assign exc_valid_dc3 = any_fault_dc3 & dc3.pkt.valid & ~dc3.pkt.dma & ~flush_dc3;

   // Type 0 is misaligned, 1 covers access faults and bus errors
   assign exc_type_dc3  = ~dc3.misaligned_fault;
   assign exc_store_dc3 = dc3.pkt.valid & dc3.pkt.store;
   assign exc_addr_dc3  = dc3.addr;

   //************************************************************************
   // DC5 commit
   //************************************************************************
   assign lsu_commit_dc5 = pkt_dc5.valid & (pkt_dc5.load | pkt_dc5.store) &
                           ~pkt_dc5.dma & ~flush_dc5;

endmodule

// File: hdl/lsu_ctl_top.sv
//**************************************************************************
// LSU control pipeline top
//**************************************************************************
module lsu_ctl_top (
   input  logic               clk,
   input  logic               rst_n,
   // Core request
   input  logic               core_valid,
   input  logic               core_load,
   input  logic               core_store,
   input  logic               core_unsign,
   input  lsu_pkg::lsu_size_e core_size,
   input  lsu_pkg::addr_t     core_rs1,
   input  lsu_pkg::offset_t   core_offset,
   // Flushes per stage
   input  logic               flush_dc2_up,
   input  logic               flush_dc3,
   input  logic               flush_dc4,
   input  logic               flush_dc5,
   // DMA request
   input  logic               dma_dccm_req,
   input  lsu_pkg::addr_t     dma_mem_addr,
   input  logic [2:0]         dma_mem_sz,
   input  logic               dma_mem_write,
   // Load data and bus status at DC3
   input  lsu_pkg::data_t     lsu_ld_data_dc3,
   input  lsu_pkg::data_t     bus_read_data_dc3,
   input  logic               ld_bus_error_dc3,
   // Addresses and regions
   output lsu_pkg::addr_t     lsu_addr_dc1,
   output lsu_pkg::addr_t     lsu_addr_dc3,
   output lsu_pkg::addr_t     lsu_addr_dc5,
   output logic               addr_in_dccm_dc3,
   output logic               addr_in_pic_dc3,
   output logic               addr_external_dc3,
   // Results, exceptions and commit
   output lsu_pkg::data_t     lsu_result_dc3,
   output logic               lsu_exc_dc2,
   output logic               exc_valid_dc3,
   output logic               exc_type_dc3,
   output logic               exc_store_dc3,
   output lsu_pkg::addr_t     exc_addr_dc3,
   output logic               lsu_commit_dc5
);

   lsu_pkg::lsu_pkt_t pkt_dc5;

   lsu_stage_if dc1_if ();
   lsu_stage_if dc3_if ();

   lsu_dc1_stage u_dc1_stage (
      .clk           (clk),
      .rst_n         (rst_n),
      .core_valid    (core_valid),
      .core_load     (core_load),
      .core_store    (core_store),
      .core_unsign   (core_unsign),
      .core_size     (core_size),
      .core_rs1      (core_rs1),
      .core_offset   (core_offset),
      .flush_dc2_up  (flush_dc2_up),
      .dma_dccm_req  (dma_dccm_req),
      .dma_mem_addr  (dma_mem_addr),
      .dma_mem_sz    (dma_mem_sz),
      .dma_mem_write (dma_mem_write),
      .dc1           (dc1_if.gen)
   );

   lsu_addrcheck u_addrcheck (
      .dc1 (dc1_if.chk)
   );

   lsu_stage_pipe u_stage_pipe (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush_dc2_up (flush_dc2_up),
      .flush_dc3    (flush_dc3),
      .flush_dc4    (flush_dc4),
      .dc1          (dc1_if.snk),
      .dc3          (dc3_if.src),
      .lsu_exc_dc2  (lsu_exc_dc2),
      .pkt_dc5      (pkt_dc5),
      .lsu_addr_dc5 (lsu_addr_dc5)
   );

   lsu_ld_align u_ld_align (
      .dc3               (dc3_if.snk),
      .lsu_ld_data_dc3   (lsu_ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .lsu_result_dc3    (lsu_result_dc3)
   );

   lsu_trap_commit u_trap_commit (
      .dc3              (dc3_if.snk),
      .ld_bus_error_dc3 (ld_bus_error_dc3),
      .flush_dc3        (flush_dc3),
      .pkt_dc5          (pkt_dc5),
      .flush_dc5        (flush_dc5),
      .exc_valid_dc3    (exc_valid_dc3),
      .exc_type_dc3     (exc_type_dc3),
      .exc_store_dc3    (exc_store_dc3),
      .exc_addr_dc3     (exc_addr_dc3),
      .lsu_commit_dc5   (lsu_commit_dc5)
   );

   // Stage taps to the outside
   assign lsu_addr_dc1      = dc1_if.addr;
   assign lsu_addr_dc3      = dc3_if.addr;
   assign addr_in_dccm_dc3  = dc3_if.in_dccm;
   assign addr_in_pic_dc3   = dc3_if.in_pic;
   assign addr_external_dc3 = dc3_if.external;

endmodule

// File: verif/lsu_ctl_assert.sv
//**************************************************************************
// LSU control pipeline assertions
//**************************************************************************
module lsu_ctl_assert (
   input logic clk,
   input logic rst_n,
   input logic addr_in_dccm_dc3,
   input logic addr_in_pic_dc3,
   input logic addr_external_dc3,
   input logic flush_dc5,
   input logic lsu_commit_dc5,
   input logic exc_valid_dc3,
   input logic exc_store_dc3
);
   timeunit 1ns;
   timeprecision 100ps;

   // DC3 flags settle one cycle after reset is released
   region_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> $onehot({addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc3}))
      else $error("DC3 region flags are not one-hot");

   no_commit_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flush_dc5 |-> !lsu_commit_dc5)
      else $error("lsu_commit_dc5 high while flush_dc5 is set");

   // Valids are cleared at the first reset edge
   quiet_in_reset: assert property (@(posedge clk)
      (!rst_n && $past(!rst_n)) |-> (!exc_valid_dc3 && !exc_store_dc3))
      else $error("DC3 exception outputs active during reset");

endmodule

bind lsu_ctl_top lsu_ctl_assert u_lsu_ctl_assert (
   .clk               (clk),
   .rst_n             (rst_n),
   .addr_in_dccm_dc3  (addr_in_dccm_dc3),
   .addr_in_pic_dc3   (addr_in_pic_dc3),
   .addr_external_dc3 (addr_external_dc3),
   .flush_dc5         (flush_dc5),
   .lsu_commit_dc5    (lsu_commit_dc5),
   .exc_valid_dc3     (exc_valid_dc3),
   .exc_store_dc3     (exc_store_dc3)
);

// File: verif/lsu_ctl_tb.sv
//**************************************************************************
// LSU control pipeline testbench
//**************************************************************************
`include "lsu_params.svh"

module lsu_ctl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int             NUM_TESTS = 5;
   localparam lsu_pkg::addr_t DCCM_BASE = `LSU_DCCM_BASE;
   localparam lsu_pkg::addr_t PIC_BASE  = `LSU_PIC_BASE;
   localparam lsu_pkg::addr_t EXT_BASE  = 32'h4000_0000;

   logic               clk;
   logic               rst_n;
   logic               core_valid;
   logic               core_load;
   logic               core_store;
   logic               core_unsign;
   lsu_pkg::lsu_size_e core_size;
   lsu_pkg::addr_t     core_rs1;
   lsu_pkg::offset_t   core_offset;
   logic               flush_dc2_up;
   logic               flush_dc3;
   logic               flush_dc4;
   logic               flush_dc5;
   logic               dma_dccm_req;
   lsu_pkg::addr_t     dma_mem_addr;
   logic [2:0]         dma_mem_sz;
   logic               dma_mem_write;
   lsu_pkg::data_t     lsu_ld_data_dc3;
   lsu_pkg::data_t     bus_read_data_dc3;
   logic               ld_bus_error_dc3;
   lsu_pkg::addr_t     lsu_addr_dc1;
   lsu_pkg::addr_t     lsu_addr_dc3;
   lsu_pkg::addr_t     lsu_addr_dc5;
   logic               addr_in_dccm_dc3;
   logic               addr_in_pic_dc3;
   logic               addr_external_dc3;
   lsu_pkg::data_t     lsu_result_dc3;
   logic               lsu_exc_dc2;
   logic               exc_valid_dc3;
   logic               exc_type_dc3;
   logic               exc_store_dc3;
   lsu_pkg::addr_t     exc_addr_dc3;
   logic               lsu_commit_dc5;

   int    seed;
   int    err_count;
   int    check_count;
   int    test_err_base;
   string test_name;

   lsu_ctl_top u_lsu_ctl_top (.*);

   always #5 clk = ~clk;

   //************************************************************************
   // Expected values
   //************************************************************************
   // {dccm, pic, external} for a start address
   function automatic logic [2:0] expect_region(lsu_pkg::addr_t a);
      lsu_pkg::addr_t dccm_tag;
      lsu_pkg::addr_t pic_tag;
      dccm_tag = DCCM_BASE >> `LSU_DCCM_BITS;
      pic_tag  = PIC_BASE >> `LSU_PIC_BITS;
      if ((a >> `LSU_DCCM_BITS) == dccm_tag) return 3'b100;
      if ((a >> `LSU_PIC_BITS) == pic_tag) return 3'b010;
      return 3'b001;
   endfunction

   // Keep the low bytes of the access, then fill the rest by sign or zero
   function automatic lsu_pkg::data_t format_load(lsu_pkg::data_t d, lsu_pkg::lsu_size_e sz,
                                                  logic uns);
      int             nbits;
      lsu_pkg::data_t keep;
      nbits = 8 << sz;
      if (nbits >= `LSU_DATA_W) return d;
      keep = (lsu_pkg::data_t'(1) << nbits) - lsu_pkg::data_t'(1);
      if (!uns && d[nbits-1]) return (d & keep) | ~keep;
      return d & keep;
   endfunction

   //************************************************************************
   // Compare and report
   //************************************************************************
   task automatic compare_addr(string what, lsu_pkg::addr_t exp, lsu_pkg::addr_t act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_data(string what, lsu_pkg::data_t exp, lsu_pkg::data_t act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_bit(string what, logic exp, logic act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic begin_test(string name);
      test_name     = name;
      test_err_base = err_count;
   endtask

   task automatic end_test();
      if (err_count == test_err_base) begin
         $display("%s: pass", test_name);
      end else begin
         $display("%s: FAIL with %0d errors", test_name, err_count - test_err_base);
      end
   endtask

   //************************************************************************
   // Stimulus
   //************************************************************************
   // Called just after a rising edge, the request sits in D for this cycle
   task automatic drive_core(logic ld, logic st, logic uns, lsu_pkg::lsu_size_e sz,
                             lsu_pkg::addr_t rs1, lsu_pkg::offset_t off);
      core_valid  <= 1'b1;
      core_load   <= ld;
      core_store  <= st;
      core_unsign <= uns;
      core_size   <= sz;
      core_rs1    <= rs1;
      core_offset <= off;
   endtask

   task automatic drive_dma(lsu_pkg::addr_t addr, logic [2:0] sz, logic wr);
      dma_dccm_req  <= 1'b1;
      dma_mem_addr  <= addr;
      dma_mem_sz    <= sz;
      dma_mem_write <= wr;
   endtask

   // One stage forward; flush is {dc5, dc4, dc3, dc2_up} for the new cycle
   task automatic step(logic [3:0] flush, logic berr);
      @(posedge clk);
      core_valid       <= 1'b0;
      dma_dccm_req     <= 1'b0;
      flush_dc2_up     <= flush[0];
      flush_dc3        <= flush[1];
      flush_dc4        <= flush[2];
      flush_dc5        <= flush[3];
      ld_bus_error_dc3 <= berr;
      @(negedge clk);
   endtask

   //************************************************************************
   // Tests
   //************************************************************************
   task automatic test_addr_decode();
      int               i;
      lsu_pkg::addr_t   rs1;
      lsu_pkg::addr_t   exp_addr;
      lsu_pkg::offset_t off;
      logic [2:0]       region;
      begin_test("addr_decode");
      for (i = 0; i < 12; i++) begin
         case (i % 3)
            0:       rs1 = DCCM_BASE | ($random(seed) & 32'h0000_FFFF);
            1:       rs1 = PIC_BASE | ($random(seed) & 32'h0000_7FFF);
            default: rs1 = EXT_BASE | ($random(seed) & 32'h0FFF_FFFF);
         endcase
         off      = lsu_pkg::offset_t'($random(seed));
         exp_addr = rs1 + lsu_pkg::addr_t'(off);
         region   = expect_region(exp_addr);
         @(posedge clk);
         drive_core(1'b1, 1'b0, 1'b0, lsu_pkg::SZ_BYTE, rs1, off);
         step(4'h0, 1'b0);
         compare_addr("addr_dc1", exp_addr, lsu_addr_dc1);
         step(4'h0, 1'b0);
         step(4'h0, 1'b0);
         compare_addr("addr_dc3", exp_addr, lsu_addr_dc3);
         compare_bit("in_dccm", region[2], addr_in_dccm_dc3);
         compare_bit("in_pic", region[1], addr_in_pic_dc3);
         compare_bit("external", region[0], addr_external_dc3);
      end
      end_test();
   endtask

   task automatic test_load_format();
      int                 r;
      int                 s;
      int                 u;
      lsu_pkg::lsu_size_e sz;
      lsu_pkg::addr_t     rs1;
      lsu_pkg::data_t     dccm_d;
      lsu_pkg::data_t     bus_d;
      begin_test("load_format");
      for (r = 0; r < 2; r++) begin
         for (s = 0; s < 4; s++) begin
            for (u = 0; u < 2; u++) begin
               sz     = lsu_pkg::lsu_size_e'(s[1:0]);
               rs1    = r[0] ? EXT_BASE + 32'h100 : DCCM_BASE + 32'h100;
               // Sign bits set in the DCCM word so extension shows
               dccm_d = {$random(seed), $random(seed)} | 64'h0000_0000_8000_8080;
               bus_d  = {$random(seed), $random(seed)};
               @(posedge clk);
               drive_core(1'b1, 1'b0, u[0], sz, rs1, '0);
               lsu_ld_data_dc3   <= dccm_d;
               bus_read_data_dc3 <= bus_d;
               step(4'h0, 1'b0);
               step(4'h0, 1'b0);
               step(4'h0, 1'b0);
               compare_data("result", format_load(r[0] ? bus_d : dccm_d, sz, u[0]),
                            lsu_result_dc3);
            end
         end
      end
      end_test();
   endtask

   task automatic run_fault(string what, lsu_pkg::lsu_size_e sz, lsu_pkg::addr_t rs1,
                            logic berr, logic exp_dc2, logic exp_valid, logic exp_type);
      @(posedge clk);
      drive_core(1'b1, 1'b0, 1'b0, sz, rs1, '0);
      step(4'h0, 1'b0);
      step(4'h0, 1'b0);
      compare_bit({what, " exc_dc2"}, exp_dc2, lsu_exc_dc2);
      step(4'h0, berr);
      compare_bit({what, " exc_valid"}, exp_valid, exc_valid_dc3);
      if (exp_valid) begin
         compare_bit({what, " exc_type"}, exp_type, exc_type_dc3);
         compare_addr({what, " exc_addr"}, rs1, exc_addr_dc3);
      end
   endtask

   task automatic test_faults();
      begin_test("faults");
      run_fault("misaligned", lsu_pkg::SZ_WORD, EXT_BASE + 32'h2, 1'b0, 1'b1, 1'b1, 1'b0);
      run_fault("pic_byte", lsu_pkg::SZ_BYTE, PIC_BASE + 32'h4, 1'b0, 1'b1, 1'b1, 1'b1);
      run_fault("dccm_cross", lsu_pkg::SZ_DWORD, DCCM_BASE + 32'hFFFC, 1'b0, 1'b1, 1'b1, 1'b1);
      run_fault("aligned", lsu_pkg::SZ_WORD, EXT_BASE + 32'h10, 1'b0, 1'b0, 1'b0, 1'b0);
      run_fault("bus_error", lsu_pkg::SZ_WORD, EXT_BASE + 32'h20, 1'b1, 1'b0, 1'b1, 1'b1);
      end_test();
   endtask

   // fstage picks the stage that sees a flush, 0 for none
   task automatic run_commit(string what, logic st, int fstage, logic exp_commit);
      int             k;
      lsu_pkg::addr_t rs1;
      rs1 = DCCM_BASE + 32'h200;
      @(posedge clk);
      drive_core(~st, st, 1'b0, lsu_pkg::SZ_WORD, rs1, '0);
      step(4'h0, 1'b0);
      for (k = 2; k <= 5; k++) begin
         step((fstage == k) ? 4'b0001 << (k - 2) : 4'h0, 1'b0);
      end
      compare_bit({what, " commit"}, exp_commit, lsu_commit_dc5);
      compare_addr({what, " addr_dc5"}, rs1, lsu_addr_dc5);
   endtask

   task automatic test_flush_commit();
      begin_test("flush_commit");
      run_commit("load", 1'b0, 0, 1'b1);
      run_commit("store", 1'b1, 0, 1'b1);
      run_commit("flush_dc2", 1'b0, 2, 1'b0);
      run_commit("flush_dc3", 1'b1, 3, 1'b0);
      run_commit("flush_dc4", 1'b0, 4, 1'b0);
      run_commit("flush_dc5", 1'b1, 5, 1'b0);
      end_test();
   endtask

   task automatic test_dma();
      lsu_pkg::data_t dccm_d;
      begin_test("dma");
      // Both requests at once, DMA address wins and no offset is added
      @(posedge clk);
      drive_core(1'b1, 1'b0, 1'b0, lsu_pkg::SZ_WORD, EXT_BASE, 12'h100);
      drive_dma(DCCM_BASE + 32'h40, 3'b010, 1'b0);
      step(4'h0, 1'b0);
      compare_addr("both addr_dc1", DCCM_BASE + 32'h40, lsu_addr_dc1);
      repeat (4) step(4'h0, 1'b0);
      compare_bit("both commit", 1'b0, lsu_commit_dc5);

      // Misaligned DMA store is seen at DC2 but never trapped
      @(posedge clk);
      drive_dma(EXT_BASE + 32'h3, 3'b010, 1'b1);
      step(4'h0, 1'b0);
      step(4'h0, 1'b0);
      compare_bit("fault exc_dc2", 1'b1, lsu_exc_dc2);
      step(4'h0, 1'b0);
      compare_bit("fault exc_valid", 1'b0, exc_valid_dc3);
      step(4'h0, 1'b0);
      step(4'h0, 1'b0);
      compare_bit("fault commit", 1'b0, lsu_commit_dc5);

      // DMA half load under flush_dc2_up from D through DC2
      dccm_d = {$random(seed), $random(seed)} | 64'h0000_0000_0000_8000;
      @(posedge clk);
      drive_dma(DCCM_BASE + 32'h80, 3'b001, 1'b0);
      flush_dc2_up    <= 1'b1;
      lsu_ld_data_dc3 <= dccm_d;
      step(4'b0001, 1'b0);
      step(4'b0001, 1'b0);
      step(4'h0, 1'b0);
      compare_addr("flush addr_dc3", DCCM_BASE + 32'h80, lsu_addr_dc3);
      compare_data("flush result", format_load(dccm_d, lsu_pkg::SZ_HALF, 1'b0), lsu_result_dc3);

      // DMA store under the same flush is still a live store in DC3
      @(posedge clk);
      drive_dma(DCCM_BASE + 32'hC0, 3'b010, 1'b1);
      flush_dc2_up <= 1'b1;
      step(4'b0001, 1'b0);
      step(4'b0001, 1'b0);
      step(4'h0, 1'b0);
      compare_bit("flush exc_store", 1'b1, exc_store_dc3);
      end_test();
   endtask

   //************************************************************************
   // Main sequence and watchdog
   //************************************************************************
   initial begin
      seed              = 13062;
      err_count         = 0;
      check_count       = 0;
      clk               = 1'b0;
      rst_n             = 1'b0;
      core_valid        = 1'b0;
      core_load         = 1'b0;
      core_store        = 1'b0;
      core_unsign       = 1'b0;
      core_size         = lsu_pkg::SZ_BYTE;
      core_rs1          = '0;
      core_offset       = '0;
      flush_dc2_up      = 1'b0;
      flush_dc3         = 1'b0;
      flush_dc4         = 1'b0;
      flush_dc5         = 1'b0;
      dma_dccm_req      = 1'b0;
      dma_mem_addr      = '0;
      dma_mem_sz        = '0;
      dma_mem_write     = 1'b0;
      lsu_ld_data_dc3   = '0;
      bus_read_data_dc3 = '0;
      ld_bus_error_dc3  = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      test_addr_decode();
      test_load_format();
      test_faults();
      test_flush_commit();
      test_dma();

      $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count,
               err_count);
      if (err_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // About 40 cycles per test plus reset margin
   initial begin
      #((NUM_TESTS * 40 + 100) * 10);
      $display("Watchdog expired before all tests finished");
      $display("Test failed");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_stage_if.sv
hdl/lsu_dc1_stage.sv
hdl/lsu_addrcheck.sv
hdl/lsu_stage_pipe.sv
hdl/lsu_ld_align.sv
hdl/lsu_trap_commit.sv
hdl/lsu_ctl_top.sv
verif/lsu_ctl_assert.sv
verif/lsu_ctl_tb.sv

// File: Makefile
# Verilator flow for the LSU control pipeline

TOP = lsu_ctl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
